// ==== flist.f ====
rtl/light_pkg.sv
rtl/matrix_pkg.sv
rtl/tick_gen.sv
rtl/phase_ctrl.sv
rtl/dot_matrix_scan.sv
rtl/traffic_display_top.sv
tests/tb_clock.sv
tests/traffic_display_asserts.sv
tests/traffic_display_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= traffic_display_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_input.txt ====
# hold secs lamps digit, one test per line, secs counted on from the previous test
# lamps in hex: 1 red, 2 yellow, 4 green
0 0 1 5
0 1 1 4
0 2 1 2
0 2 1 0
0 1 4 4
0 2 4 2
0 2 4 0
0 1 2 2
0 1 2 1
0 1 2 0
0 1 1 5
0 2 1 3
1 3 1 3
1 2 1 3
0 1 1 2
0 3 4 4
1 2 4 4
0 1 4 3

// ==== tests/traffic_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_display_tb;

    localparam int clk_per_scan = 4;
    localparam int scan_per_sec = 16;
    localparam int sec_cycles   = clk_per_scan * scan_per_sec;
    localparam int n            = matrix_pkg::mat_n;
    localparam int dw           = light_pkg::digit_w;
    localparam int max_tests    = 64;
    localparam int scan_lat     = 2; // row_idx one clock after scan_tick, row one more

    logic         clk;
    logic         rst;
    logic         hold;
    logic [2:0]   lamps;
    logic [n-1:0] row;
    logic [n-1:0] colr;
    logic [n-1:0] colg;

    int test_hold  [max_tests];
    int test_secs  [max_tests];
    int test_lamps [max_tests];
    int test_digit [max_tests];
    int n_tests    = 0;
    int n_checks   = 0;
    int n_errors   = 0;
    int cyc        = 0; // clocks since reset release
    int elapsed    = 0; // seconds covered so far
    int limit_cyc  = 0;

    tb_clock #(.period_ns(8.0)) u_clk (.clk(clk));

    traffic_display_top #(
        .clk_per_scan (clk_per_scan),
        .scan_per_sec (scan_per_sec),
        .red_secs     (6),
        .green_secs   (5),
        .yellow_secs  (3)
    ) u_dut (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .lamps (lamps),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    always @(posedge clk)
    begin
        if (!rst)
            cyc <= cyc + 1;
    end

    // digit bitmaps, row 0 on the left
    function automatic logic [n-1:0] font_row(input logic [dw-1:0] d, input int r);
        logic [8*n-1:0] rows;
        case (d)
            3'd0:    rows = {8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c};
            3'd1:    rows = {8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7e};
            3'd2:    rows = {8'h00, 8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e};
            3'd3:    rows = {8'h00, 8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c};
            3'd4:    rows = {8'h00, 8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c};
            3'd5:    rows = {8'h00, 8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c};
            default: rows = '0;
        endcase
        return rows[(n-1-r)*n +: n];
    endfunction

    task automatic compare_word(input string name, input logic [n-1:0] got,
                                input logic [n-1:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_lamps(input logic [2:0] got, input logic [2:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR lamps got 0x%h expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    // one sample per scan row, eight rows in a row
    task automatic check_frame(input logic [dw-1:0] exp_digit, input logic [2:0] exp_lamps);
        logic         show_r;
        logic         show_g;
        logic [n-1:0] glyph;
        int           r_exp;
        int           k;
        show_r = exp_lamps[light_pkg::lamp_red] || exp_lamps[light_pkg::lamp_yellow];
        show_g = exp_lamps[light_pkg::lamp_green] || exp_lamps[light_pkg::lamp_yellow];
        for (k = 0; k < n; k++)
        begin
            r_exp = ((cyc - scan_lat) / clk_per_scan) % n; // row from the scan time base
            glyph = font_row(exp_digit, r_exp);
            compare_word("row", row, ~(n'(1) << r_exp));
            compare_word("colr", colr, show_r ? glyph : '0);
            compare_word("colg", colg, show_g ? glyph : '0);
            if (k < n - 1)
                repeat (clk_per_scan) @(negedge clk);
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    h;
        int    s;
        int    l;
        int    d;
        string line;
        fd = $fopen("tests/tb_input.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tests/tb_input.txt");
            return;
        end
        while (!$feof(fd) && n_tests < max_tests)
        begin
            if ($fgets(line, fd) == 0)
                break;
            if ($sscanf(line, "%d %d %h %d", h, s, l, d) == 4) // comments fall through
            begin
                test_hold[n_tests]  = h;
                test_secs[n_tests]  = s;
                test_lamps[n_tests] = l;
                test_digit[n_tests] = d;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int idx);
        int start;
        int errs_before;
        errs_before = n_errors;
        @(posedge clk);
        hold <= test_hold[idx][0];
        elapsed += test_secs[idx];
        // early in the second, clear of both boundaries
        start = elapsed * sec_cycles + 2 * clk_per_scan + int'($urandom % (2 * clk_per_scan));
        if (start <= cyc)
        begin
            $display("test %0d starts before the previous check has ended", idx);
            n_errors++;
        end
        else
        begin
            while (cyc < start)
                @(negedge clk);
            check_lamps(lamps, 3'(test_lamps[idx]));
            check_frame(dw'(test_digit[idx]), 3'(test_lamps[idx]));
        end
        $display("test %0d hold=%0d at %0d s: %s", idx, test_hold[idx], elapsed,
                 (n_errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial
    begin
        int i;
        int total;
        rst   = 1'b1;
        hold  = 1'b0;
        total = 0;
        void'($urandom(26));
        load_tests();
        if (n_tests == 0)
        begin
            $display("no tests could be read from tests/tb_input.txt");
            n_errors++;
        end
        else
        begin
            for (i = 0; i < n_tests; i++)
                total += test_secs[i];
            limit_cyc = (total + 4) * sec_cycles;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            for (i = 0; i < n_tests; i++)
                run_test(i);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (limit_cyc > 0);
        while (cyc < limit_cyc)
            @(negedge clk);
        $display("timeout after %0d clocks, the tests did not finish", cyc);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/traffic_display_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_display_asserts #(
    parameter bit scan_side = 1'b0
) (
    input logic                          clk,
    input logic                          rst,
    input logic [matrix_pkg::mat_n-1:0]  row,
    input logic [2:0]                    lamps,
    input logic [light_pkg::digit_w-1:0] digit,
    input logic                          hold
);

    logic started; // set once the first row has been driven

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            started <= 1'b0;
        else
            started <= 1'b1;
    end

    if (scan_side)
    begin : g_scan
        a_row_onehot: assert property (@(posedge clk) disable iff (rst)
            started |-> $onehot(~row))
            else $error("row select not one-hot active low: %h", row);
    end
    else
    begin : g_phase
        a_lamps_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot(lamps))
            else $error("lamps not one-hot: %h", lamps);
        // a tick seen under hold must leave the count alone
        a_hold_freeze: assert property (@(posedge clk) disable iff (rst)
            hold && $past(hold) |-> $stable(digit))
            else $error("digit moved under hold: %h", digit);
    end

endmodule

bind dot_matrix_scan traffic_display_asserts #(.scan_side(1'b1)) u_scan_asserts (
    .clk   (clk),
    .rst   (rst),
    .row   (row),
    .lamps (3'b001),
    .digit (digit),
    .hold  (1'b0)
);

bind phase_ctrl traffic_display_asserts #(.scan_side(1'b0)) u_phase_asserts (
    .clk   (clk),
    .rst   (rst),
    .row   (8'hfe),
    .lamps (lamps),
    .digit (digit),
    .hold  (hold)
);

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period_ns = 8.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk; // free running
    end

endmodule

`default_nettype wire

// ==== rtl/traffic_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_display_top #(
    parameter int clk_per_scan = 1000,
    parameter int scan_per_sec = 1000,
    parameter int red_secs     = 6,
    parameter int green_secs   = 5,
    parameter int yellow_secs  = 3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hold,
    output logic [2:0]                   lamps,
    output logic [matrix_pkg::mat_n-1:0] row,
    output logic [matrix_pkg::mat_n-1:0] colr,
    output logic [matrix_pkg::mat_n-1:0] colg
);

    logic                          scan_tick;
    logic                          sec_tick;
    logic [light_pkg::digit_w-1:0] digit;
    logic [1:0]                    color;

    // shared time base for refresh and countdown
    tick_gen #(
        .clk_per_scan (clk_per_scan),
        .scan_per_sec (scan_per_sec)
    ) u_tick (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .sec_tick  (sec_tick)
    );

    phase_ctrl #(
        .red_secs    (red_secs),
        .green_secs  (green_secs),
        .yellow_secs (yellow_secs)
    ) u_phase (
        .clk      (clk),
        .rst      (rst),
        .sec_tick (sec_tick),
        .hold     (hold),
        .lamps    (lamps),
        .digit    (digit),
        .color    (color)
    );

    dot_matrix_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .digit     (digit),
        .color     (color),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

`default_nettype wire

// ==== rtl/dot_matrix_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_matrix_scan (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           scan_tick,
    input  logic [light_pkg::digit_w-1:0]  digit,
    input  logic [1:0]                     color,
    output logic [matrix_pkg::mat_n-1:0]   row,
    output logic [matrix_pkg::mat_n-1:0]   colr,
    output logic [matrix_pkg::mat_n-1:0]   colg
);

    localparam int n  = matrix_pkg::mat_n;
    localparam int rw = $clog2(n);

    localparam logic [rw-1:0] last_row = rw'(n - 1);

    logic [light_pkg::digit_w-1:0] digit_q;
    logic [1:0]                    color_q;
    logic [rw-1:0]                 row_idx;
    logic [n-1:0]                  glyph;
    logic                          show_r;
    logic                          show_g;

    // latch the number and colour
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit_q <= '0;
            color_q <= '0;
        end
        else
        begin
            digit_q <= digit;
            color_q <= color;
        end
    end

    // one row per scan tick
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (scan_tick)
            row_idx <= (row_idx == last_row) ? '0 : row_idx + rw'(1);
    end

    assign glyph  = matrix_pkg::glyph_row(digit_q, row_idx);
    assign show_r = (color_q == matrix_pkg::color_red) ||
                    (color_q == matrix_pkg::color_yellow);
    assign show_g = (color_q == matrix_pkg::color_green) ||
                    (color_q == matrix_pkg::color_yellow);

    // row select and columns leave on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1; // all rows off
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(n'(1) << row_idx); // active low
            colr <= show_r ? glyph : '0;
            colg <= show_g ? glyph : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/phase_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_ctrl #(
    parameter int red_secs    = 6,
    parameter int green_secs  = 5,
    parameter int yellow_secs = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sec_tick,
    input  logic                          hold,
    output logic [2:0]                    lamps,
    output logic [light_pkg::digit_w-1:0] digit,
    output logic [1:0]                    color
);

    localparam int dw = light_pkg::digit_w;

    // count loaded on entry to each phase
    localparam logic [dw-1:0] red_last    = dw'(red_secs - 1);
    localparam logic [dw-1:0] green_last  = dw'(green_secs - 1);
    localparam logic [dw-1:0] yellow_last = dw'(yellow_secs - 1);

    logic [1:0]    phase;
    logic [1:0]    phase_nxt;
    logic [dw-1:0] cnt_nxt;

    function automatic logic [2:0] lamp_of(input logic [1:0] ph);
        logic [2:0] l;
        l = '0;
        case (ph)
            light_pkg::phase_green:  l[light_pkg::lamp_green]  = 1'b1;
            light_pkg::phase_yellow: l[light_pkg::lamp_yellow] = 1'b1;
            default:                 l[light_pkg::lamp_red]    = 1'b1;
        endcase
        return l;
    endfunction

    function automatic logic [1:0] color_of(input logic [1:0] ph);
        case (ph)
            light_pkg::phase_green:  return matrix_pkg::color_green;
            light_pkg::phase_yellow: return matrix_pkg::color_yellow;
            default:                 return matrix_pkg::color_red;
        endcase
    endfunction

    // digit doubles as the seconds-remaining counter
    always_comb
    begin
        phase_nxt = phase;
        cnt_nxt   = digit;
        if (sec_tick && !hold) // hold freezes the countdown
        begin
            if (digit != '0)
                cnt_nxt = digit - dw'(1);
            else
            begin
                case (phase)
                    light_pkg::phase_red:
                    begin
                        phase_nxt = light_pkg::phase_green;
                        cnt_nxt   = green_last;
                    end
                    light_pkg::phase_green:
                    begin
                        phase_nxt = light_pkg::phase_yellow;
                        cnt_nxt   = yellow_last;
                    end
                    default:
                    begin
                        phase_nxt = light_pkg::phase_red;
                        cnt_nxt   = red_last;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase <= light_pkg::phase_red;
            digit <= red_last;
            lamps <= lamp_of(light_pkg::phase_red);
            color <= matrix_pkg::color_red;
        end
        else
        begin
            phase <= phase_nxt;
            digit <= cnt_nxt;
            lamps <= lamp_of(phase_nxt);
            color <= color_of(phase_nxt);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int clk_per_scan = 1000,
    parameter int scan_per_sec = 1000
) (
    input  logic clk,
    input  logic rst,
    output logic scan_tick,
    output logic sec_tick
);

    localparam int scan_cw = (clk_per_scan > 1) ? $clog2(clk_per_scan) : 1;
    localparam int sec_cw  = (scan_per_sec > 1) ? $clog2(scan_per_sec) : 1;

    localparam logic [scan_cw-1:0] scan_last = scan_cw'(clk_per_scan - 1);
    localparam logic [sec_cw-1:0]  sec_last  = sec_cw'(scan_per_sec - 1);

    logic [scan_cw-1:0] scan_cnt;
    logic [sec_cw-1:0]  sec_cnt;
    logic               scan_wrap;

    assign scan_wrap = (scan_cnt == scan_last);

    // clocks within one scan period
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end
        else
        begin
            scan_tick <= scan_wrap;
            scan_cnt  <= scan_wrap ? '0 : scan_cnt + scan_cw'(1);
        end
    end

    // scan ticks within one second, pulse lines up with the scan tick
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sec_cnt  <= '0;
            sec_tick <= 1'b0;
        end
        else
        begin
            sec_tick <= scan_wrap && (sec_cnt == sec_last);
            if (scan_wrap)
                sec_cnt <= (sec_cnt == sec_last) ? '0 : sec_cnt + sec_cw'(1);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

    parameter int mat_n = 8; // 8x8 bicolour matrix

    // colour codes, yellow lights both leds of a dot
    parameter logic [1:0] color_green  = 2'b01;
    parameter logic [1:0] color_red    = 2'b10;
    parameter logic [1:0] color_yellow = 2'b11;

    // column pattern for one row of a digit glyph
    // bitmaps are packed row 7 down to row 0, one byte per row
    function automatic logic [mat_n-1:0] glyph_row(
        input logic [light_pkg::digit_w-1:0] digit,
        input logic [$clog2(mat_n)-1:0]      row
    );
        logic [mat_n*mat_n-1:0] bmp;
        case (digit)
            3'd0:
            begin
                bmp = 64'h3c42_4242_4242_3c00;
            end
            3'd1:
            begin
                bmp = 64'h7e18_1818_3818_1800;
            end
            3'd2:
            begin
                bmp = 64'h7e60_300c_0666_3c00;
            end
            3'd3:
            begin
                bmp = 64'h3c66_061c_0666_3c00;
            end
            3'd4:
            begin
                bmp = 64'h0c0c_7e4c_2c1c_0c00;
            end
            3'd5:
            begin
                bmp = 64'h3c66_0606_7c60_7e00;
            end
            default:
            begin
                bmp = '0; // 6 and 7 not drawn
            end
        endcase
        // lowest byte is row 0, kept blank in every glyph
        return bmp[row*mat_n +: mat_n];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/light_pkg.sv ====
`default_nettype none

package light_pkg;

    // phase codes, stepped red -> green -> yellow -> red
    parameter logic [1:0] phase_red    = 2'd0;
    parameter logic [1:0] phase_green  = 2'd1;
    parameter logic [1:0] phase_yellow = 2'd2;

    // bit positions in the 3-bit lamp word
    parameter int lamp_red    = 0;
    parameter int lamp_yellow = 1;
    parameter int lamp_green  = 2;

    // seconds left, 0..5 shown on the matrix
    parameter int digit_w = 3;

endpackage

`default_nettype wire
